/* verilog/ntm_trainer_pkg.sv */
// Signed Q8.8 throughout, products truncate toward minus infinity and sums wrap
// Sizes are fixed at L = 4, X = 4; the memory map fills 24 words
package ntm_trainer_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////////////////////////////////////////
  localparam int DATA_W    = 16;  // Element width
  localparam int FRAC_W    = 8;   // Q8.8 fraction bits
  localparam int L_SIZE    = 4;   // Gate vector length
  localparam int X_SIZE    = 4;   // Input vector length
  localparam int STEP_W    = 4;   // Step count, T up to 8
  localparam int IDX_W     = 2;   // Element index
  localparam int ADDR_W    = 5;
  localparam int MEM_WORDS = 24;  // di, dB and dW

  typedef logic signed [DATA_W-1:0] elem_t;
  typedef logic [ADDR_W-1:0]        addr_t;
  typedef logic [IDX_W-1:0]         idx_t;

  localparam elem_t ONE_FX = elem_t'(1 << FRAC_W);  // 1.0

  // Scratch memory map
  localparam addr_t DI_BASE = 5'd0;  // di[l]
  localparam addr_t B_BASE  = 5'd4;  // dB[l]
  localparam addr_t W_BASE  = 5'd8;  // dW[l][x] at 8 + 4*l + x

  ////////////////////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {IDLE, DELTA, GRAD, FINISH} seq_state_e;

  // Read-modify-write peers
  typedef enum logic [1:0] {ACC_IDLE, ACC_RD_DI, ACC_RD_ACC, ACC_WR_ACC} acc_state_e;

  typedef enum logic [1:0] {M_DELTA, M_BIAS, M_WEIGHT} master_e;

  // Q8.8 product, low fraction bits dropped
  function automatic elem_t fx_mul(input elem_t a, input elem_t b);
    logic signed [2*DATA_W-1:0] prod;
    prod = a * b;
    return prod[FRAC_W +: DATA_W];
  endfunction

endpackage

/* verilog/ntm_trainer_sequencer.sv */
`timescale 1ns/1ps
// Runs DELTA then GRAD once per step; start is taken in IDLE only
module ntm_trainer_sequencer (
  input  logic                               CLK,
  input  logic                               RST,
  input  logic                               start,
  input  logic [ntm_trainer_pkg::STEP_W-1:0] steps,
  input  logic                               delta_done,
  input  logic                               bias_done,
  input  logic                               weight_done,
  output logic                               busy,
  output logic                               done,
  output logic                               delta_go,
  output logic                               grad_go,
  output logic                               first_step  // Step 0, writes not adds
);

  ntm_trainer_pkg::seq_state_e state;
  logic [ntm_trainer_pkg::STEP_W-1:0] step_cnt;
  logic [ntm_trainer_pkg::STEP_W-1:0] steps_r;
  logic bias_seen, weight_seen;  // Grad peer already finished
  logic bias_fin, weight_fin;

  assign bias_fin   = bias_seen | bias_done;
  assign weight_fin = weight_seen | weight_done;

  // busy drops in the single FINISH cycle where done is high
  assign busy = (state == ntm_trainer_pkg::DELTA) || (state == ntm_trainer_pkg::GRAD);
  assign done = (state == ntm_trainer_pkg::FINISH);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state       <= ntm_trainer_pkg::IDLE;
      step_cnt    <= '0;
      steps_r     <= '0;
      first_step  <= 1'b0;
      delta_go    <= 1'b0;
      grad_go     <= 1'b0;
      bias_seen   <= 1'b0;
      weight_seen <= 1'b0;
    end else begin
      delta_go <= 1'b0;  // Go lines are pulses
      grad_go  <= 1'b0;
      case (state)
        ntm_trainer_pkg::IDLE: if (start) begin
          steps_r    <= steps;
          step_cnt   <= '0;
          first_step <= 1'b1;
          delta_go   <= 1'b1;
          state      <= ntm_trainer_pkg::DELTA;
        end
        ntm_trainer_pkg::DELTA: if (delta_done) begin
          grad_go     <= 1'b1;
          bias_seen   <= 1'b0;
          weight_seen <= 1'b0;
          state       <= ntm_trainer_pkg::GRAD;
        end
        ntm_trainer_pkg::GRAD: begin
          bias_seen   <= bias_fin;
          weight_seen <= weight_fin;
          if (bias_fin && weight_fin) begin
            if (step_cnt == steps_r - 1'b1) begin
              state <= ntm_trainer_pkg::FINISH;  // Last step
            end else begin
              step_cnt   <= step_cnt + 1'b1;
              first_step <= 1'b0;
              delta_go   <= 1'b1;
              state      <= ntm_trainer_pkg::DELTA;
            end
          end
        end
        default: state <= ntm_trainer_pkg::IDLE;  // FINISH lasts one cycle
      endcase
    end
  end

endmodule

/* verilog/ntm_gate_delta.sv */
`timescale 1ns/1ps
// di = ds * a * i * (1 - i) per element, three truncated multiplies per beat
module ntm_gate_delta (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   delta_go,
  input  logic                   in_valid,
  input  ntm_trainer_pkg::elem_t in_ds,
  input  ntm_trainer_pkg::elem_t in_a,
  input  ntm_trainer_pkg::elem_t in_i,
  input  logic                   m_ack,
  output logic                   in_ready,
  output logic                   delta_done,
  output logic                   m_cyc,
  output logic                   m_stb,
  output logic                   m_we,
  output ntm_trainer_pkg::addr_t m_adr,
  output ntm_trainer_pkg::elem_t m_dat_w
);

  typedef enum logic [2:0] {D_IDLE, D_WAIT, D_MUL1, D_MUL2, D_MUL3, D_WR} delta_state_e;

  delta_state_e state;
  ntm_trainer_pkg::idx_t  l_cnt;
  ntm_trainer_pkg::elem_t ds_r, a_r, i_r;  // Latched beat
  ntm_trainer_pkg::elem_t prod_r;          // Running product

  assign in_ready = (state == D_WAIT);     // Back-pressure on the caller
  assign m_cyc    = (state == D_WR);       // Single write per cycle
  assign m_stb    = m_cyc;
  assign m_we     = 1'b1;
  assign m_adr    = ntm_trainer_pkg::DI_BASE + ntm_trainer_pkg::addr_t'(l_cnt);
  assign m_dat_w  = prod_r;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= D_IDLE;
      l_cnt      <= '0;
      delta_done <= 1'b0;
    end else begin
      delta_done <= 1'b0;
      case (state)
        D_IDLE: if (delta_go) begin
          l_cnt <= '0;
          state <= D_WAIT;
        end
        D_WAIT: if (in_valid) state <= D_MUL1;
        D_MUL1: state <= D_MUL2;
        D_MUL2: state <= D_MUL3;
        D_MUL3: state <= D_WR;
        D_WR: if (m_ack) begin
          if (l_cnt == ntm_trainer_pkg::idx_t'(ntm_trainer_pkg::L_SIZE - 1)) begin
            delta_done <= 1'b1;  // Fourth write landed
            state      <= D_IDLE;
          end else begin
            l_cnt <= l_cnt + 1'b1;
            state <= D_WAIT;
          end
        end
        default: state <= D_IDLE;
      endcase
    end
  end

  // Multiply chain, one fx_mul per cycle
  always_ff @(posedge CLK) begin
    case (state)
      D_WAIT: if (in_valid) begin
        ds_r <= in_ds;
        a_r  <= in_a;
        i_r  <= in_i;
      end
      D_MUL1: prod_r <= ntm_trainer_pkg::fx_mul(ds_r, a_r);
      D_MUL2: prod_r <= ntm_trainer_pkg::fx_mul(prod_r, i_r);
      D_MUL3: prod_r <= ntm_trainer_pkg::fx_mul(prod_r, ntm_trainer_pkg::ONE_FX - i_r);
      default: ;
    endcase
  end

endmodule

/* verilog/ntm_bias_grad.sv */
`timescale 1ns/1ps
// dB[l] += di[l]; on the first step the dB read is skipped and di is written
module ntm_bias_grad (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   grad_go,
  input  logic                   first_step,
  input  logic                   m_ack,
  input  ntm_trainer_pkg::elem_t m_rdata,
  output logic                   bias_done,
  output logic                   m_cyc,
  output logic                   m_stb,
  output logic                   m_we,
  output ntm_trainer_pkg::addr_t m_adr,
  output ntm_trainer_pkg::elem_t m_dat_w
);

  ntm_trainer_pkg::acc_state_e state;
  ntm_trainer_pkg::idx_t  l_cnt;
  ntm_trainer_pkg::elem_t sum_r;
  logic active;  // Between grad_go and bias_done

  assign m_cyc   = (state != ntm_trainer_pkg::ACC_IDLE);  // One RMW per cyc
  assign m_stb   = m_cyc;
  assign m_we    = (state == ntm_trainer_pkg::ACC_WR_ACC);
  assign m_adr   = (state == ntm_trainer_pkg::ACC_RD_DI) ?
                   ntm_trainer_pkg::DI_BASE + ntm_trainer_pkg::addr_t'(l_cnt) :
                   ntm_trainer_pkg::B_BASE + ntm_trainer_pkg::addr_t'(l_cnt);
  assign m_dat_w = sum_r;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ntm_trainer_pkg::ACC_IDLE;
      l_cnt     <= '0;
      active    <= 1'b0;
      bias_done <= 1'b0;
    end else begin
      bias_done <= 1'b0;
      case (state)
        ntm_trainer_pkg::ACC_IDLE: begin
          if (grad_go) begin
            active <= 1'b1;
            l_cnt  <= '0;
          end
          if (grad_go || active) state <= ntm_trainer_pkg::ACC_RD_DI;
        end
        ntm_trainer_pkg::ACC_RD_DI: if (m_ack) begin
          state <= first_step ? ntm_trainer_pkg::ACC_WR_ACC : ntm_trainer_pkg::ACC_RD_ACC;
        end
        ntm_trainer_pkg::ACC_RD_ACC: if (m_ack) state <= ntm_trainer_pkg::ACC_WR_ACC;
        default: if (m_ack) begin  // WR_ACC, cyc drops for a cycle
          state <= ntm_trainer_pkg::ACC_IDLE;
          l_cnt <= l_cnt + 1'b1;
          if (l_cnt == ntm_trainer_pkg::idx_t'(ntm_trainer_pkg::L_SIZE - 1)) begin
            active    <= 1'b0;
            bias_done <= 1'b1;
          end
        end
      endcase
    end
  end

  // Wrapping 16-bit accumulate
  always_ff @(posedge CLK) begin
    if (m_ack && state == ntm_trainer_pkg::ACC_RD_DI) sum_r <= m_rdata;
    else if (m_ack && state == ntm_trainer_pkg::ACC_RD_ACC) sum_r <= sum_r + m_rdata;
  end

endmodule

/* verilog/ntm_weight_grad.sv */
`timescale 1ns/1ps
// dW[l][x] += di[l] * x per x beat, looping l inside; first step skips the dW read
module ntm_weight_grad (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   grad_go,
  input  logic                   first_step,
  input  logic                   x_valid,
  input  ntm_trainer_pkg::elem_t in_x,
  input  logic                   m_ack,
  input  ntm_trainer_pkg::elem_t m_rdata,
  output logic                   x_ready,
  output logic                   weight_done,
  output logic                   m_cyc,
  output logic                   m_stb,
  output logic                   m_we,
  output ntm_trainer_pkg::addr_t m_adr,
  output ntm_trainer_pkg::elem_t m_dat_w
);

  ntm_trainer_pkg::acc_state_e state;
  ntm_trainer_pkg::idx_t  l_cnt, x_cnt;
  ntm_trainer_pkg::elem_t x_r, di_r, acc_r;
  logic active;  // Phase running
  logic x_held;  // x beat taken, l loop pending

  assign x_ready = active && !x_held && (state == ntm_trainer_pkg::ACC_IDLE);
  assign m_cyc   = (state != ntm_trainer_pkg::ACC_IDLE);
  assign m_stb   = m_cyc;
  assign m_we    = (state == ntm_trainer_pkg::ACC_WR_ACC);
  assign m_adr   = (state == ntm_trainer_pkg::ACC_RD_DI) ?
                   ntm_trainer_pkg::DI_BASE + ntm_trainer_pkg::addr_t'(l_cnt) :
                   ntm_trainer_pkg::W_BASE + ntm_trainer_pkg::addr_t'(l_cnt) *
                   ntm_trainer_pkg::addr_t'(ntm_trainer_pkg::X_SIZE) +
                   ntm_trainer_pkg::addr_t'(x_cnt);
  assign m_dat_w = acc_r + ntm_trainer_pkg::fx_mul(di_r, x_r);  // Wraps

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state       <= ntm_trainer_pkg::ACC_IDLE;
      l_cnt       <= '0;
      x_cnt       <= '0;
      active      <= 1'b0;
      x_held      <= 1'b0;
      weight_done <= 1'b0;
    end else begin
      weight_done <= 1'b0;
      case (state)
        ntm_trainer_pkg::ACC_IDLE: begin
          if (grad_go) begin
            active <= 1'b1;
            x_held <= 1'b0;
            l_cnt  <= '0;
            x_cnt  <= '0;
          end else if (x_ready && x_valid) x_held <= 1'b1;
          else if (x_held) state <= ntm_trainer_pkg::ACC_RD_DI;
        end
        ntm_trainer_pkg::ACC_RD_DI: if (m_ack) begin
          state <= first_step ? ntm_trainer_pkg::ACC_WR_ACC : ntm_trainer_pkg::ACC_RD_ACC;
        end
        ntm_trainer_pkg::ACC_RD_ACC: if (m_ack) state <= ntm_trainer_pkg::ACC_WR_ACC;
        default: if (m_ack) begin  // WR_ACC
          state <= ntm_trainer_pkg::ACC_IDLE;
          l_cnt <= l_cnt + 1'b1;
          if (l_cnt == ntm_trainer_pkg::idx_t'(ntm_trainer_pkg::L_SIZE - 1)) begin
            x_held <= 1'b0;  // Ready for next x
            x_cnt  <= x_cnt + 1'b1;
            if (x_cnt == ntm_trainer_pkg::idx_t'(ntm_trainer_pkg::X_SIZE - 1)) begin
              active      <= 1'b0;
              weight_done <= 1'b1;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (x_ready && x_valid) x_r <= in_x;
    if (m_ack && state == ntm_trainer_pkg::ACC_RD_DI) begin
      di_r  <= m_rdata;
      acc_r <= '0;  // First step writes the bare term
    end
    if (m_ack && state == ntm_trainer_pkg::ACC_RD_ACC) acc_r <= m_rdata;
  end

endmodule

/* verilog/ntm_bus_arbiter.sv */
`timescale 1ns/1ps
// Round-robin Wishbone arbiter, grant held while the owner keeps cyc high
module ntm_bus_arbiter (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   d_cyc, d_stb, d_we,
  input  ntm_trainer_pkg::addr_t d_adr,
  input  ntm_trainer_pkg::elem_t d_dat_w,
  output logic                   d_ack,
  input  logic                   b_cyc, b_stb, b_we,
  input  ntm_trainer_pkg::addr_t b_adr,
  input  ntm_trainer_pkg::elem_t b_dat_w,
  output logic                   b_ack,
  input  logic                   w_cyc, w_stb, w_we,
  input  ntm_trainer_pkg::addr_t w_adr,
  input  ntm_trainer_pkg::elem_t w_dat_w,
  output logic                   w_ack,
  output logic                   s_cyc, s_stb, s_we,
  output ntm_trainer_pkg::addr_t s_adr,
  output ntm_trainer_pkg::elem_t s_dat_w,
  input  logic                   s_ack
);

  ntm_trainer_pkg::master_e gnt, rr_ptr, nxt;  // rr_ptr has top priority
  logic owned;                                 // Bus held by gnt
  logic sel_cyc, sel_stb;

  // Next requester from rr_ptr onwards
  always_comb begin
    case (rr_ptr)
      ntm_trainer_pkg::M_DELTA:
        nxt = d_cyc ? ntm_trainer_pkg::M_DELTA : b_cyc ? ntm_trainer_pkg::M_BIAS
                                               : ntm_trainer_pkg::M_WEIGHT;
      ntm_trainer_pkg::M_BIAS:
        nxt = b_cyc ? ntm_trainer_pkg::M_BIAS : w_cyc ? ntm_trainer_pkg::M_WEIGHT
                                              : ntm_trainer_pkg::M_DELTA;
      default:
        nxt = w_cyc ? ntm_trainer_pkg::M_WEIGHT : d_cyc ? ntm_trainer_pkg::M_DELTA
                                                : ntm_trainer_pkg::M_BIAS;
    endcase
  end

  // Owner mux
  always_comb begin
    case (gnt)
      ntm_trainer_pkg::M_DELTA: {sel_cyc, sel_stb, s_we, s_adr, s_dat_w} =
                                {d_cyc, d_stb, d_we, d_adr, d_dat_w};
      ntm_trainer_pkg::M_BIAS:  {sel_cyc, sel_stb, s_we, s_adr, s_dat_w} =
                                {b_cyc, b_stb, b_we, b_adr, b_dat_w};
      default:                  {sel_cyc, sel_stb, s_we, s_adr, s_dat_w} =
                                {w_cyc, w_stb, w_we, w_adr, w_dat_w};
    endcase
  end

  assign s_cyc = owned & sel_cyc;
  assign s_stb = owned & sel_stb;
  assign d_ack = s_ack & owned & (gnt == ntm_trainer_pkg::M_DELTA);  // Owner only
  assign b_ack = s_ack & owned & (gnt == ntm_trainer_pkg::M_BIAS);
  assign w_ack = s_ack & owned & (gnt == ntm_trainer_pkg::M_WEIGHT);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      gnt    <= ntm_trainer_pkg::M_DELTA;
      rr_ptr <= ntm_trainer_pkg::M_DELTA;
      owned  <= 1'b0;
    end else if (owned) begin
      if (!sel_cyc) owned <= 1'b0;  // Owner dropped cyc
    end else if (d_cyc || b_cyc || w_cyc) begin
      gnt   <= nxt;
      owned <= 1'b1;
      case (nxt)                    // Winner goes to the back
        ntm_trainer_pkg::M_DELTA: rr_ptr <= ntm_trainer_pkg::M_BIAS;
        ntm_trainer_pkg::M_BIAS:  rr_ptr <= ntm_trainer_pkg::M_WEIGHT;
        default:                  rr_ptr <= ntm_trainer_pkg::M_DELTA;
      endcase
    end
  end

endmodule

/* verilog/ntm_scratch_ram.sv */
`timescale 1ns/1ps
// 24-word scratch memory; ack one cycle after cyc&stb, never two in a row
module ntm_scratch_ram (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   s_cyc,
  input  logic                   s_stb,
  input  logic                   s_we,
  input  ntm_trainer_pkg::addr_t s_adr,
  input  ntm_trainer_pkg::elem_t s_dat_w,
  input  ntm_trainer_pkg::addr_t rd_addr,  // Readout port
  output logic                   s_ack,
  output ntm_trainer_pkg::elem_t s_rdata,
  output ntm_trainer_pkg::elem_t rd_data
);

  ntm_trainer_pkg::elem_t mem [ntm_trainer_pkg::MEM_WORDS];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) s_ack <= 1'b0;
    else     s_ack <= s_cyc & s_stb & ~s_ack;  // One ack per strobe
  end

  always_ff @(posedge CLK) begin
    if (s_cyc && s_stb && s_we && !s_ack) mem[s_adr] <= s_dat_w;
    s_rdata <= mem[s_adr];   // Valid with ack
    rd_data <= mem[rd_addr];
  end

endmodule

/* verilog/ntm_input_trainer.sv */
`timescale 1ns/1ps
// Input-gate gradient trainer, L = 4 and X = 4 fixed, T from 1 to 8
// Results are read back through rd_addr/rd_data, meaningful only while busy is low
module ntm_input_trainer (
  input  logic                               CLK,
  input  logic                               RST,
  input  logic                               start,
  input  logic [ntm_trainer_pkg::STEP_W-1:0] steps,    // T
  input  logic                               in_valid, // ds/a/i stream
  output logic                               in_ready,
  input  ntm_trainer_pkg::elem_t             in_ds,
  input  ntm_trainer_pkg::elem_t             in_a,
  input  ntm_trainer_pkg::elem_t             in_i,
  input  logic                               x_valid,  // x stream
  output logic                               x_ready,
  input  ntm_trainer_pkg::elem_t             in_x,
  output logic                               busy,
  output logic                               done,
  input  ntm_trainer_pkg::addr_t             rd_addr,  // Readout port
  output ntm_trainer_pkg::elem_t             rd_data
);

  // Sequencer handshakes
  logic delta_go, grad_go, first_step;
  logic delta_done, bias_done, weight_done;

  // Wishbone masters, d = delta, b = bias, w = weight
  logic d_cyc, d_stb, d_we, d_ack;
  logic b_cyc, b_stb, b_we, b_ack;
  logic w_cyc, w_stb, w_we, w_ack;
  ntm_trainer_pkg::addr_t d_adr, b_adr, w_adr;
  ntm_trainer_pkg::elem_t d_dat_w, b_dat_w, w_dat_w;

  // Slave side
  logic s_cyc, s_stb, s_we, s_ack;
  ntm_trainer_pkg::addr_t s_adr;
  ntm_trainer_pkg::elem_t s_dat_w, s_rdata;

  ntm_trainer_sequencer u_seq (
    .CLK, .RST, .start, .steps, .delta_done, .bias_done, .weight_done,
    .busy, .done, .delta_go, .grad_go, .first_step
  );

  ntm_gate_delta u_delta (
    .CLK, .RST, .delta_go, .in_valid, .in_ds, .in_a, .in_i,
    .m_ack(d_ack), .in_ready, .delta_done,
    .m_cyc(d_cyc), .m_stb(d_stb), .m_we(d_we), .m_adr(d_adr), .m_dat_w(d_dat_w)
  );

  ntm_bias_grad u_bias (
    .CLK, .RST, .grad_go, .first_step, .m_ack(b_ack), .m_rdata(s_rdata),
    .bias_done,
    .m_cyc(b_cyc), .m_stb(b_stb), .m_we(b_we), .m_adr(b_adr), .m_dat_w(b_dat_w)
  );

  ntm_weight_grad u_weight (
    .CLK, .RST, .grad_go, .first_step, .x_valid, .in_x,
    .m_ack(w_ack), .m_rdata(s_rdata), .x_ready, .weight_done,
    .m_cyc(w_cyc), .m_stb(w_stb), .m_we(w_we), .m_adr(w_adr), .m_dat_w(w_dat_w)
  );

  ntm_bus_arbiter u_arb (
    .CLK, .RST,
    .d_cyc, .d_stb, .d_we, .d_adr, .d_dat_w, .d_ack,
    .b_cyc, .b_stb, .b_we, .b_adr, .b_dat_w, .b_ack,
    .w_cyc, .w_stb, .w_we, .w_adr, .w_dat_w, .w_ack,
    .s_cyc, .s_stb, .s_we, .s_adr, .s_dat_w, .s_ack
  );

  ntm_scratch_ram u_ram (
    .CLK, .RST, .s_cyc, .s_stb, .s_we, .s_adr, .s_dat_w, .rd_addr,
    .s_ack, .s_rdata, .rd_data
  );

endmodule

/* dv/ntm_input_trainer_assert.sv */
`timescale 1ns/1ps
// Bus and control rules of the trainer, bound to the top level
// Watches the Wishbone wires and handshakes inside the top level
module ntm_input_trainer_assert (
  input logic                   CLK,
  input logic                   RST,
  input logic                   start,
  input logic                   busy,
  input logic                   done,
  input logic                   in_ready,
  input logic                   x_ready,
  input logic                   s_cyc,
  input logic                   s_ack,
  input logic                   d_cyc, d_stb, d_we, d_ack,
  input ntm_trainer_pkg::addr_t d_adr,
  input logic                   b_cyc, b_stb, b_we, b_ack,
  input ntm_trainer_pkg::addr_t b_adr,
  input logic                   w_cyc, w_stb, w_we, w_ack,
  input ntm_trainer_pkg::addr_t w_adr
);

  ////////////////////////////////////////////////////////////////////////////
  // Reset and idle
  ////////////////////////////////////////////////////////////////////////////
  reset_quiet: assert property (@(posedge CLK) $past(RST) |->
      !in_ready && !x_ready && !busy && !done && !s_cyc && !d_cyc && !b_cyc && !w_cyc)
    else $error("outputs or cyc high just after reset");

  // No start, stays idle
  idle_hold: assert property (@(posedge CLK) disable iff (RST)
      !busy && !done && !start |=> !busy && !done)
    else $error("left idle without start");

  idle_no_ready: assert property (@(posedge CLK) disable iff (RST)
      !busy |-> !in_ready && !x_ready)
    else $error("stream ready while not busy");

  ////////////////////////////////////////////////////////////////////////////
  // Done pulse
  ////////////////////////////////////////////////////////////////////////////
  done_on_fall: assert property (@(posedge CLK) disable iff (RST) done |-> $fell(busy))
    else $error("done without busy falling");

  done_single: assert property (@(posedge CLK) disable iff (RST) done |=> !done)
    else $error("done longer than one cycle");

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone rules
  ////////////////////////////////////////////////////////////////////////////
  // Every slave ack lands on exactly one granted master
  grant_onehot: assert property (@(posedge CLK) disable iff (RST)
      s_ack |-> $onehot({d_ack, b_ack, w_ack}))
    else $error("slave ack not owned by a single master");

  d_ack_stb: assert property (@(posedge CLK) disable iff (RST) d_ack |-> d_stb)
    else $error("delta ack without stb");
  b_ack_stb: assert property (@(posedge CLK) disable iff (RST) b_ack |-> b_stb)
    else $error("bias ack without stb");
  w_ack_stb: assert property (@(posedge CLK) disable iff (RST) w_ack |-> w_stb)
    else $error("weight ack without stb");

  s_ack_gap: assert property (@(posedge CLK) disable iff (RST) s_ack |=> !s_ack)
    else $error("slave ack two cycles in a row");

  // Request held until acked
  d_hold: assert property (@(posedge CLK) disable iff (RST)
      d_stb && !d_ack |=> d_stb && $stable(d_adr) && $stable(d_we))
    else $error("delta request changed before ack");
  b_hold: assert property (@(posedge CLK) disable iff (RST)
      b_stb && !b_ack |=> b_stb && $stable(b_adr) && $stable(b_we))
    else $error("bias request changed before ack");
  w_hold: assert property (@(posedge CLK) disable iff (RST)
      w_stb && !w_ack |=> w_stb && $stable(w_adr) && $stable(w_we))
    else $error("weight request changed before ack");

endmodule

bind ntm_input_trainer ntm_input_trainer_assert u_assert (
  .CLK(CLK), .RST(RST), .start(start), .busy(busy), .done(done),
  .in_ready(in_ready), .x_ready(x_ready), .s_cyc(s_cyc), .s_ack(s_ack),
  .d_cyc(d_cyc), .d_stb(d_stb), .d_we(d_we), .d_ack(d_ack), .d_adr(d_adr),
  .b_cyc(b_cyc), .b_stb(b_stb), .b_we(b_we), .b_ack(b_ack), .b_adr(b_adr),
  .w_cyc(w_cyc), .w_stb(w_stb), .w_we(w_we), .w_ack(w_ack), .w_adr(w_adr)
);

/* dv/tb_ntm_input_trainer.sv */
`timescale 1ns/1ps
// Runs T = 1 then T = 5 with random stream gaps and reads back all 24 words
// Inputs change 2 ns after the rising edge, outputs sampled on the falling edge
module tb_ntm_input_trainer;

  localparam int  MAX_T          = 8;
  localparam int  RUN1_T         = 1;
  localparam int  RUN2_T         = 5;
  localparam int  TIMEOUT_CYCLES = 400 * (RUN1_T + RUN2_T) + 200;
  localparam time DRIVE_DLY      = 2ns;

  logic CLK, RST, start;
  logic [ntm_trainer_pkg::STEP_W-1:0] steps;
  logic in_valid, in_ready, x_valid, x_ready, busy, done;
  ntm_trainer_pkg::elem_t in_ds, in_a, in_i, in_x, rd_data;
  ntm_trainer_pkg::addr_t rd_addr;

  // Stimulus and model per run
  ntm_trainer_pkg::elem_t ds_s [MAX_T][ntm_trainer_pkg::L_SIZE];
  ntm_trainer_pkg::elem_t a_s  [MAX_T][ntm_trainer_pkg::L_SIZE];
  ntm_trainer_pkg::elem_t i_s  [MAX_T][ntm_trainer_pkg::L_SIZE];
  ntm_trainer_pkg::elem_t x_s  [MAX_T][ntm_trainer_pkg::X_SIZE];
  ntm_trainer_pkg::elem_t di_m [MAX_T][ntm_trainer_pkg::L_SIZE];
  ntm_trainer_pkg::elem_t db_m [ntm_trainer_pkg::L_SIZE];
  ntm_trainer_pkg::elem_t dw_m [ntm_trainer_pkg::L_SIZE][ntm_trainer_pkg::X_SIZE];
  int e_gap [MAX_T][ntm_trainer_pkg::L_SIZE];  // Idle cycles before each beat
  int x_gap [MAX_T][ntm_trainer_pkg::X_SIZE];

  logic [31:0] seed   = 32'h3f7c;
  int          cycles = 0;

  ntm_input_trainer u_dut (
    .CLK, .RST, .start, .steps, .in_valid, .in_ready, .in_ds, .in_a, .in_i,
    .x_valid, .x_ready, .in_x, .busy, .done, .rd_addr, .rd_data
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;  // 40 ns period
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  // Watchdog over the whole run
  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) abort_run("timeout, done never came");
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  // Q8.8 value within +-2.0
  function automatic ntm_trainer_pkg::elem_t rand_fx();
    logic [31:0] r;
    r = next_rand();
    return {{6{r[25]}}, r[25:16]};
  endfunction

  function automatic int rand_gap();
    return int'(next_rand() >> 30);  // 0 to 3
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and reference model
  ////////////////////////////////////////////////////////////////////////////
  task automatic make_run(input int t_n);
    for (int l = 0; l < ntm_trainer_pkg::L_SIZE; l++) begin
      db_m[l] = '0;  // Sum from zero equals first-step write
      for (int x = 0; x < ntm_trainer_pkg::X_SIZE; x++) dw_m[l][x] = '0;
    end
    for (int t = 0; t < t_n; t++) begin
      for (int l = 0; l < ntm_trainer_pkg::L_SIZE; l++) begin
        ds_s[t][l]  = rand_fx();
        a_s[t][l]   = rand_fx();
        i_s[t][l]   = rand_fx();
        e_gap[t][l] = rand_gap();
        di_m[t][l]  = ntm_trainer_pkg::fx_mul(ntm_trainer_pkg::fx_mul(
                        ntm_trainer_pkg::fx_mul(ds_s[t][l], a_s[t][l]), i_s[t][l]),
                        ntm_trainer_pkg::ONE_FX - i_s[t][l]);
        db_m[l]     = db_m[l] + di_m[t][l];  // Wraps at 16 bits
      end
      for (int x = 0; x < ntm_trainer_pkg::X_SIZE; x++) begin
        x_s[t][x]   = rand_fx();
        x_gap[t][x] = rand_gap();
        for (int l = 0; l < ntm_trainer_pkg::L_SIZE; l++)
          dw_m[l][x] = dw_m[l][x] + ntm_trainer_pkg::fx_mul(di_m[t][l], x_s[t][x]);
      end
    end
  endtask

  // ds/a/i stream, beat taken when ready is seen before the edge
  task automatic feed_elems(input int t_n);
    for (int t = 0; t < t_n; t++) begin
      for (int l = 0; l < ntm_trainer_pkg::L_SIZE; l++) begin
        repeat (e_gap[t][l]) begin
          @(posedge CLK);
          #DRIVE_DLY;
        end
        in_valid = 1'b1;
        in_ds    = ds_s[t][l];
        in_a     = a_s[t][l];
        in_i     = i_s[t][l];
        do @(negedge CLK); while (!in_ready);
        @(posedge CLK);
        #DRIVE_DLY;
        in_valid = 1'b0;
      end
    end
  endtask

  task automatic feed_x(input int t_n);
    for (int t = 0; t < t_n; t++) begin
      for (int x = 0; x < ntm_trainer_pkg::X_SIZE; x++) begin
        repeat (x_gap[t][x]) begin
          @(posedge CLK);
          #DRIVE_DLY;
        end
        x_valid = 1'b1;
        in_x    = x_s[t][x];
        do @(negedge CLK); while (!x_ready);
        @(posedge CLK);
        #DRIVE_DLY;
        x_valid = 1'b0;
      end
    end
  endtask

  // Stray start mid-run, different T on steps
  task automatic poke_start();
    repeat (60) @(posedge CLK);
    #DRIVE_DLY;
    assert (busy) else abort_run("trainer not busy when the stray start was sent");
    steps = 4'd2;
    start = 1'b1;
    @(posedge CLK);
    #DRIVE_DLY;
    start = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Readout
  ////////////////////////////////////////////////////////////////////////////
  task automatic read_word(input ntm_trainer_pkg::addr_t addr,
                           output ntm_trainer_pkg::elem_t val);
    rd_addr = addr;
    @(posedge CLK);  // Registered read
    @(negedge CLK);
    val = rd_data;
    @(posedge CLK);
    #DRIVE_DLY;
  endtask

  task automatic expect_word(input string name, input ntm_trainer_pkg::elem_t got,
                             input ntm_trainer_pkg::elem_t exp);
    assert (got === exp) else begin
      $display("** Error at %0t: rd_data for %s = %h, expected %h", $time, name, got, exp);
      abort_run("readout mismatch");
    end
  endtask

  task automatic check_results(input int t_n);
    ntm_trainer_pkg::elem_t got;
    for (int l = 0; l < ntm_trainer_pkg::L_SIZE; l++) begin
      read_word(ntm_trainer_pkg::addr_t'(ntm_trainer_pkg::DI_BASE + l), got);
      expect_word($sformatf("di[%0d]", l), got, di_m[t_n-1][l]);  // Last step only
      read_word(ntm_trainer_pkg::addr_t'(ntm_trainer_pkg::B_BASE + l), got);
      expect_word($sformatf("dB[%0d]", l), got, db_m[l]);
    end
    for (int l = 0; l < ntm_trainer_pkg::L_SIZE; l++) begin
      for (int x = 0; x < ntm_trainer_pkg::X_SIZE; x++) begin
        read_word(ntm_trainer_pkg::addr_t'(ntm_trainer_pkg::W_BASE +
                  ntm_trainer_pkg::X_SIZE * l + x), got);
        expect_word($sformatf("dW[%0d][%0d]", l, x), got, dw_m[l][x]);
      end
    end
  endtask

  task automatic run_case(input int t_n, input bit stray_start);
    make_run(t_n);
    @(posedge CLK);
    #DRIVE_DLY;
    steps = t_n[ntm_trainer_pkg::STEP_W-1:0];
    start = 1'b1;
    @(posedge CLK);
    #DRIVE_DLY;
    start = 1'b0;
    fork
      feed_elems(t_n);
      feed_x(t_n);
      if (stray_start) poke_start();
    join
    do @(negedge CLK); while (!done);
    @(posedge CLK);
    #DRIVE_DLY;
    check_results(t_n);
  endtask

  initial begin
    RST      = 1'b1;
    start    = 1'b0;
    steps    = '0;
    in_valid = 1'b0;
    in_ds    = '0;
    in_a     = '0;
    in_i     = '0;
    x_valid  = 1'b0;
    in_x     = '0;
    rd_addr  = '0;
    repeat (5) @(posedge CLK);
    #DRIVE_DLY;
    RST = 1'b0;
    repeat (3) @(posedge CLK);  // Idle, no start
    #DRIVE_DLY;
    run_case(RUN1_T, 1'b0);
    run_case(RUN2_T, 1'b1);
    $display("TEST PASS");
    $finish;
  end

endmodule

/* src.f */
verilog/ntm_trainer_pkg.sv
verilog/ntm_trainer_sequencer.sv
verilog/ntm_gate_delta.sv
verilog/ntm_bias_grad.sv
verilog/ntm_weight_grad.sv
verilog/ntm_bus_arbiter.sv
verilog/ntm_scratch_ram.sv
verilog/ntm_input_trainer.sv
dv/ntm_input_trainer_assert.sv
dv/tb_ntm_input_trainer.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run; exit status is the test result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
  --top-module tb_ntm_input_trainer \
  -f src.f \
  -o sim_ntm_input_trainer
./obj_dir/sim_ntm_input_trainer
